// File: Bender.yml
package:
  name: udp_engine

sources:
  - source/net_pkg.sv
  - source/stream_pkg.sv
  - source/stream_if.sv
  - source/beat_fifo.sv
  - source/ipv4_checksum.sv
  - source/udp_tx_framer.sv
  - source/udp_rx_parser.sv
  - source/udp_engine_top.sv
  - target: simulation
    files:
      - bench/udp_engine_props.sv
      - bench/udp_engine_tb.sv

// File: bench/udp_engine_props.sv
`timescale 1ns/1ps

module udp_engine_props import stream_pkg::*; (
    input logic  clk,
    input logic  reset,
    input word_t tx_data,
    input logic  tx_valid,
    input logic  tx_last,
    input logic  tx_ready,
    input logic  payload_out_valid
);

    // both output streams are quiet right after a reset cycle
    reset_quiet: assert property (@(posedge clk) reset |=> (!tx_valid && !payload_out_valid))
        else $error("output valid high right after reset");

    // a stalled tx beat keeps its valid and its data
    tx_hold: assert property (@(posedge clk) disable iff (reset)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
        else $error("tx beat changed while stalled");

    tx_last_valid: assert property (@(posedge clk) disable iff (reset)
        tx_last |-> tx_valid)
        else $error("tx_last high without tx_valid");

endmodule

bind udp_engine_top udp_engine_props props0 (.*);

// File: bench/udp_engine_tb.sv
`timescale 1ns/1ps

module udp_engine_tb import net_pkg::*, stream_pkg::*; ();

    localparam int WAIT_LIMIT = 4000;

    // address and port fields of one frame header
    typedef struct packed {
        mac_t       dst_mac;
        mac_t       src_mac;
        ip_t        src_ip;
        ip_t        dst_ip;
        port_t      src_port;
        port_t      dst_port;
        len_t       psize;
        logic [7:0] proto;
    } hdr_fields_t;

    logic  clk;
    logic  reset;
    word_t rx_data;
    logic  rx_valid;
    logic  rx_last;
    logic  rx_ready;
    word_t tx_data;
    logic  tx_valid;
    logic  tx_last;
    logic  tx_ready;
    word_t payload_in_data;
    logic  payload_in_valid;
    logic  payload_in_ready;
    word_t payload_out_data;
    logic  payload_out_valid;
    logic  payload_out_last;
    logic  payload_out_ready;
    len_t  packet_size;
    mac_t  local_mac;
    ip_t   local_ip;
    port_t local_port;
    mac_t  remote_mac;
    ip_t   remote_ip;
    port_t remote_port;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    beat_t       exp_q[$];
    beat_t       rx_q[$];

    udp_engine_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] ip_checksum(len_t total_len, ip_t src, ip_t dst);
        logic [31:0] acc;
        acc = IP_VER_IHL_TOS + total_len + IP_FLAGS_FRAG + IP_TTL_PROTO
            + src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
        // end-around carry until nothing is left above bit 15
        while (acc[31:16] != 16'h0000) begin
            acc = acc[31:16] + acc[15:0];
        end
        return ~acc[15:0];
    endfunction

    function automatic word_t header_word(hdr_fields_t h, int idx);
        len_t ip_len;
        len_t udp_len;
        ip_len  = h.psize + len_t'(IP_LEN_EXTRA);
        udp_len = h.psize + len_t'(UDP_LEN_EXTRA);
        case (idx)
            0: return h.dst_mac[47:16];
            1: return {h.dst_mac[15:0], h.src_mac[47:32]};
            2: return h.src_mac[31:0];
            3: return {ETHERTYPE_IPV4, IP_VER_IHL_TOS};
            4: return {ip_len, 16'h0000};
            5: return {IP_FLAGS_FRAG, 8'hff, h.proto};
            6: return {ip_checksum(ip_len, h.src_ip, h.dst_ip), h.src_ip[31:16]};
            7: return {h.src_ip[15:0], h.dst_ip[31:16]};
            8: return {h.dst_ip[15:0], h.src_port};
            9: return {h.dst_port, udp_len};
            default: return 32'h0;
        endcase
    endfunction

    function automatic hdr_fields_t tx_fields();
        hdr_fields_t h;
        h.dst_mac  = remote_mac;
        h.src_mac  = local_mac;
        h.src_ip   = local_ip;
        h.dst_ip   = remote_ip;
        h.src_port = local_port;
        h.dst_port = remote_port;
        h.psize    = packet_size;
        h.proto    = IP_PROTO_UDP;
        return h;
    endfunction

    // a frame from the remote end addressed to this engine
    function automatic hdr_fields_t rx_fields(len_t psize);
        hdr_fields_t h;
        h.dst_mac  = local_mac;
        h.src_mac  = remote_mac;
        h.src_ip   = remote_ip;
        h.dst_ip   = local_ip;
        h.src_port = remote_port;
        h.dst_port = local_port;
        h.psize    = psize;
        h.proto    = IP_PROTO_UDP;
        return h;
    endfunction

    ////////////////////////////////////////
    // stream helpers
    ////////////////////////////////////////

    task automatic check_beat(string name, int pos, word_t data, logic last);
        checks++;
        if (pos >= exp_q.size()) begin
            errors++;
            $display("Error %s: unexpected extra beat %0d with data %h", name, pos, data);
        end else begin
            if (data !== exp_q[pos].data) begin
                errors++;
                $display("Error %s: word %0d expected %h actual %h",
                         name, pos, exp_q[pos].data, data);
            end
            if (last !== exp_q[pos].last) begin
                errors++;
                $display("Error %s: last of word %0d expected %b actual %b",
                         name, pos, exp_q[pos].last, last);
            end
        end
    endtask

    task automatic add_rx_frame(hdr_fields_t h, int extra, bit accept);
        int    i;
        int    n;
        beat_t b;
        n = h.psize / 4;
        for (i = 0; i < HDR_WORDS; i++) begin
            b.data = header_word(h, i);
            b.last = 1'b0;
            rx_q.push_back(b);
        end
        for (i = 0; i < n + extra; i++) begin
            b.data = next_rand();
            b.last = (i == n + extra - 1);
            rx_q.push_back(b);
            if (accept && i < n) begin
                b.last = (i == n - 1);
                exp_q.push_back(b);
            end
        end
    endtask

    task automatic run_tx(string name, int frames, bit gaps);
        int    words;
        int    sent;
        int    got;
        int    lasts;
        int    cycles;
        int    f;
        int    i;
        bit    pending;
        word_t r;
        word_t pay_q[$];
        beat_t b;
        exp_q.delete();
        words = packet_size / 4;
        for (f = 0; f < frames; f++) begin
            for (i = 0; i < HDR_WORDS; i++) begin
                b.data = header_word(tx_fields(), i);
                b.last = 1'b0;
                exp_q.push_back(b);
            end
            for (i = 0; i < words; i++) begin
                b.data = next_rand();
                b.last = (i == words - 1);
                pay_q.push_back(b.data);
                exp_q.push_back(b);
            end
        end
        sent    = 0;
        got     = 0;
        lasts   = 0;
        cycles  = 0;
        pending = 1'b0;
        while (got < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            // a beat that was offered stays on the bus until it transfers
            if (!pending) begin
                r = next_rand();
                payload_in_valid = (sent < pay_q.size()) && (!gaps || r[31:30] != 2'b00);
                if (sent < pay_q.size()) begin
                    payload_in_data = pay_q[sent];
                end
            end
            r = next_rand();
            tx_ready = !gaps || r[31:30] != 2'b00;
            @(posedge clk);
            if (payload_in_valid) begin
                pending = !payload_in_ready;
                if (payload_in_ready) begin
                    sent++;
                end
            end
            if (tx_valid && tx_ready) begin
                if (tx_last) begin
                    lasts++;
                end
                check_beat(name, got, tx_data, tx_last);
                got++;
            end
            cycles++;
        end
        @(negedge clk);
        payload_in_valid = 1'b0;
        tx_ready         = 1'b1;
        checks++;
        if (got < exp_q.size()) begin
            errors++;
            $display("Error %s: timeout with %0d of %0d frame words seen",
                     name, got, exp_q.size());
        end
        checks++;
        if (lasts != frames) begin
            errors++;
            $display("Error %s: last beats expected %0d actual %0d", name, frames, lasts);
        end
        repeat (2) @(negedge clk);
        checks++;
        if (tx_valid) begin
            errors++;
            $display("Error %s: tx_valid still high after the final frame", name);
        end
        exp_q.delete();
    endtask

    // sends rx_q and compares payload_out against exp_q
    task automatic run_rx(string name, bit gaps);
        int    idx;
        int    got;
        int    idle;
        int    cycles;
        word_t r;
        idx    = 0;
        got    = 0;
        idle   = 0;
        cycles = 0;
        while (idle < 40 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            rx_valid = (idx < rx_q.size());
            if (rx_valid) begin
                rx_data = rx_q[idx].data;
                rx_last = rx_q[idx].last;
            end
            r = next_rand();
            payload_out_ready = !gaps || r[31:30] != 2'b00;
            @(posedge clk);
            if (rx_valid && rx_ready) begin
                idx++;
            end
            if (payload_out_valid && payload_out_ready) begin
                check_beat(name, got, payload_out_data, payload_out_last);
                got++;
            end
            if (idx == rx_q.size() && got >= exp_q.size()) begin
                idle++;
            end
            cycles++;
        end
        @(negedge clk);
        rx_valid          = 1'b0;
        rx_last           = 1'b0;
        payload_out_ready = 1'b1;
        checks++;
        if (cycles >= WAIT_LIMIT) begin
            errors++;
            $display("Error %s: timeout with %0d of %0d payload words seen",
                     name, got, exp_q.size());
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_tx_single();
        run_tx("tx_single", 1, 1'b0);
    endtask

    task automatic test_tx_back_to_back();
        packet_size = 16'd64;
        // let the checksum pipeline settle on the new length
        repeat (10) @(negedge clk);
        run_tx("tx_back_to_back", 2, 1'b1);
    endtask

    task automatic test_rx_local();
        add_rx_frame(rx_fields(16'd32), 0, 1'b1);
        run_rx("rx_local", 1'b0);
    endtask

    task automatic test_rx_broadcast_trailing();
        hdr_fields_t h;
        h = rx_fields(16'd16);
        h.dst_mac = BROADCAST_MAC;
        add_rx_frame(h, 0, 1'b1);
        add_rx_frame(rx_fields(16'd12), 3, 1'b1);
        run_rx("rx_broadcast_trailing", 1'b0);
    endtask

    task automatic test_rx_rejects();
        hdr_fields_t h;
        h = rx_fields(16'd20);
        h.dst_port = local_port + 16'd1;
        add_rx_frame(h, 0, 1'b0);
        h = rx_fields(16'd20);
        h.proto = 8'h06;
        add_rx_frame(h, 0, 1'b0);
        h = rx_fields(16'd20);
        h.dst_ip = local_ip ^ 32'h0000_0001;
        add_rx_frame(h, 0, 1'b0);
        add_rx_frame(rx_fields(16'd24), 0, 1'b1);
        run_rx("rx_rejects", 1'b0);
    endtask

    task automatic test_rx_backpressure();
        add_rx_frame(rx_fields(16'd64), 0, 1'b1);
        add_rx_frame(rx_fields(16'd40), 0, 1'b1);
        run_rx("rx_backpressure", 1'b1);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        errors            = 0;
        checks            = 0;
        lcg_state         = 32'hd09deeca;
        reset             = 1'b1;
        rx_data           = '0;
        rx_valid          = 1'b0;
        rx_last           = 1'b0;
        tx_ready          = 1'b1;
        payload_in_data   = '0;
        payload_in_valid  = 1'b0;
        payload_out_ready = 1'b1;
        packet_size       = 16'd16;
        local_mac         = 48'h02a1_b2c3_d4e5;
        local_ip          = 32'hc0a8_010a;
        local_port        = 16'h1f90;
        remote_mac        = 48'h0216_2738_495a;
        remote_ip         = 32'hc0a8_0114;
        remote_port       = 16'h2328;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (10) @(negedge clk);

        test_tx_single();
        test_tx_back_to_back();
        test_rx_local();
        test_rx_broadcast_trailing();
        test_rx_rejects();
        test_rx_backpressure();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim.f
source/net_pkg.sv
source/stream_pkg.sv
source/stream_if.sv
source/beat_fifo.sv
source/ipv4_checksum.sv
source/udp_tx_framer.sv
source/udp_rx_parser.sv
source/udp_engine_top.sv
bench/udp_engine_props.sv
bench/udp_engine_tb.sv

// File: source/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo import stream_pkg::*; #(
    parameter type item_t = word_t,
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  item_t in_item,
    output logic  in_ready,
    output logic  out_valid,
    output item_t out_item,
    input  logic  out_ready
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    item_t mem [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    cnt_t  count;
    logic  push;
    logic  pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    assign in_ready  = (count != cnt_t'(DEPTH));
    assign out_valid = (count != '0);

    // read side shows the head entry directly
    assign out_item = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            // simultaneous push and pop leaves the count unchanged
            if (push && !pop) begin
                count <= count + cnt_t'(1);
            end else if (pop && !push) begin
                count <= count - cnt_t'(1);
            end
        end
    end

endmodule

// File: source/ipv4_checksum.sv
`timescale 1ns/1ps

module ipv4_checksum import net_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  len_t        ip_total_len,
    input  ip_t         src_ip,
    input  ip_t         dst_ip,
    output logic [15:0] checksum
);

    logic [31:0] sum_s1;
    logic [31:0] sum_s2;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_s1   <= '0;
            sum_s2   <= '0;
            checksum <= '0;
        end else begin
            // identification and checksum fields count as zero
            sum_s1 <= 32'(IP_VER_IHL_TOS) + 32'(ip_total_len)
                    + 32'(IP_FLAGS_FRAG) + 32'(IP_TTL_PROTO)
                    + 32'(src_ip[31:16]) + 32'(src_ip[15:0])
                    + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);

            // first carry fold
            sum_s2 <= 32'(sum_s1[31:16]) + 32'(sum_s1[15:0]);

            // second fold absorbs the carry left by the first
            checksum <= ~(sum_s2[31:16] + sum_s2[15:0]);
        end
    end

endmodule

// File: source/net_pkg.sv
package net_pkg;

    ////////////////////////////////////////
    // field types
    ////////////////////////////////////////

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;

    ////////////////////////////////////////
    // ethernet and ipv4 constants
    ////////////////////////////////////////

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;

    // version 4, ihl 5, tos 0
    localparam logic [15:0] IP_VER_IHL_TOS = 16'h4500;
    // don't fragment, offset 0
    localparam logic [15:0] IP_FLAGS_FRAG  = 16'h4000;
    // ttl 255, protocol udp
    localparam logic [15:0] IP_TTL_PROTO   = 16'hff11;

    localparam mac_t BROADCAST_MAC = '1;

    ////////////////////////////////////////
    // frame layout
    ////////////////////////////////////////

    // eth 14 + ipv4 20 + udp 8 + 2 pad bytes = 44 bytes
    localparam int HDR_WORDS = 11;

    // udp length counts the two pad bytes as well
    localparam int UDP_LEN_EXTRA = 10;
    localparam int IP_LEN_EXTRA  = 30;

endpackage

// File: source/stream_if.sv
`timescale 1ns/1ps

// word stream with valid/ready handshake and frame end marker
interface stream_if import stream_pkg::*; ();

    word_t data;
    logic  valid;
    logic  ready;
    logic  last;

    // producer side
    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

// File: source/stream_pkg.sv
package stream_pkg;

    ////////////////////////////////////////
    // stream words and beats
    ////////////////////////////////////////

    typedef logic [31:0] word_t;

    // a word together with its frame end marker
    typedef struct packed {
        word_t data;
        logic  last;
    } beat_t;

    ////////////////////////////////////////
    // buffer sizes
    ////////////////////////////////////////

    // payload words held ahead of the framer
    localparam int TX_FIFO_DEPTH = 512;

    // received beats held ahead of the parser
    localparam int RX_FIFO_DEPTH = 512;

endpackage

// File: source/udp_engine_top.sv
`timescale 1ns/1ps

module udp_engine_top import net_pkg::*, stream_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    // incoming frames
    input  word_t rx_data,
    input  logic  rx_valid,
    input  logic  rx_last,
    output logic  rx_ready,
    // outgoing frames
    output word_t tx_data,
    output logic  tx_valid,
    output logic  tx_last,
    input  logic  tx_ready,
    // transmit payload
    input  word_t payload_in_data,
    input  logic  payload_in_valid,
    output logic  payload_in_ready,
    // received payload
    output word_t payload_out_data,
    output logic  payload_out_valid,
    output logic  payload_out_last,
    input  logic  payload_out_ready,
    // configuration
    input  len_t  packet_size,
    input  mac_t  local_mac,
    input  ip_t   local_ip,
    input  port_t local_port,
    input  mac_t  remote_mac,
    input  ip_t   remote_ip,
    input  port_t remote_port
);

    stream_if rx_beats ();
    stream_if rx_payload ();
    stream_if tx_frame ();

    beat_t       rx_in_beat;
    beat_t       rx_out_beat;
    logic        fr_payload_valid;
    logic        fr_payload_ready;
    word_t       fr_payload_data;
    len_t        ip_total_len;
    logic [15:0] checksum;

    ////////////////////////////////////////
    // receive path
    ////////////////////////////////////////

    assign rx_in_beat.data = rx_data;
    assign rx_in_beat.last = rx_last;

    beat_fifo #(.item_t(beat_t), .DEPTH(RX_FIFO_DEPTH)) rx_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rx_valid),
        .in_item   (rx_in_beat),
        .in_ready  (rx_ready),
        .out_valid (rx_beats.valid),
        .out_item  (rx_out_beat),
        .out_ready (rx_beats.ready)
    );

    assign rx_beats.data = rx_out_beat.data;
    assign rx_beats.last = rx_out_beat.last;

    udp_rx_parser parser0 (
        .clk        (clk),
        .reset      (reset),
        .local_mac  (local_mac),
        .local_ip   (local_ip),
        .local_port (local_port),
        .beats      (rx_beats.sink),
        .payload    (rx_payload.source)
    );

    assign payload_out_data  = rx_payload.data;
    assign payload_out_valid = rx_payload.valid;
    assign payload_out_last  = rx_payload.last;
    assign rx_payload.ready  = payload_out_ready;

    ////////////////////////////////////////
    // transmit path
    ////////////////////////////////////////

    beat_fifo #(.item_t(word_t), .DEPTH(TX_FIFO_DEPTH)) tx_payload_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (payload_in_valid),
        .in_item   (payload_in_data),
        .in_ready  (payload_in_ready),
        .out_valid (fr_payload_valid),
        .out_item  (fr_payload_data),
        .out_ready (fr_payload_ready)
    );

    ipv4_checksum csum0 (
        .clk          (clk),
        .reset        (reset),
        .ip_total_len (ip_total_len),
        .src_ip       (local_ip),
        .dst_ip       (remote_ip),
        .checksum     (checksum)
    );

    udp_tx_framer framer0 (
        .clk           (clk),
        .reset         (reset),
        .payload_valid (fr_payload_valid),
        .payload_data  (fr_payload_data),
        .payload_ready (fr_payload_ready),
        .packet_size   (packet_size),
        .local_mac     (local_mac),
        .local_ip      (local_ip),
        .local_port    (local_port),
        .remote_mac    (remote_mac),
        .remote_ip     (remote_ip),
        .remote_port   (remote_port),
        .checksum      (checksum),
        .ip_total_len  (ip_total_len),
        .frame         (tx_frame.source)
    );

    assign tx_data        = tx_frame.data;
    assign tx_valid       = tx_frame.valid;
    assign tx_last        = tx_frame.last;
    assign tx_frame.ready = tx_ready;

endmodule

// File: source/udp_rx_parser.sv
`timescale 1ns/1ps

module udp_rx_parser import net_pkg::*, stream_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mac_t     local_mac,
    input  ip_t      local_ip,
    input  port_t    local_port,
    stream_if.sink   beats,
    stream_if.source payload
);

    typedef enum logic [1:0] {
        P_HEADER,
        P_PAYLOAD,
        P_DISCARD
    } state_t;

    state_t     state;
    logic [3:0] hdr_cnt;
    len_t       pay_left;
    logic       hdr_ok;
    logic       beat_done;

    ////////////////////////////////////////
    // header field checks
    ////////////////////////////////////////

    always_comb begin
        case (hdr_cnt)
            4'd0: hdr_ok = (beats.data == local_mac[47:16])
                        || (beats.data == BROADCAST_MAC[47:16]);
            4'd1: hdr_ok = (beats.data[31:16] == local_mac[15:0])
                        || (beats.data[31:16] == BROADCAST_MAC[15:0]);
            4'd3: hdr_ok = (beats.data[31:16] == ETHERTYPE_IPV4);
            4'd5: hdr_ok = (beats.data[7:0] == IP_PROTO_UDP);
            4'd7: hdr_ok = (beats.data[15:0] == local_ip[31:16]);
            4'd8: hdr_ok = (beats.data[31:16] == local_ip[15:0]);
            4'd9: hdr_ok = (beats.data[31:16] == local_port);
            // a udp length with no payload word is rejected
            4'd10: hdr_ok = (pay_left != '0);
            default: hdr_ok = 1'b1;
        endcase
    end

    ////////////////////////////////////////
    // payload forwarding
    ////////////////////////////////////////

    assign beat_done = beats.valid && beats.ready;

    always_comb begin
        beats.ready   = 1'b1;
        payload.valid = 1'b0;
        if (state == P_PAYLOAD) begin
            beats.ready   = payload.ready;
            payload.valid = beats.valid;
        end
    end

    assign payload.data = beats.data;

    // a short frame still closes the payload stream
    assign payload.last = (state == P_PAYLOAD) && beats.valid
                       && ((pay_left == len_t'(1)) || beats.last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= P_HEADER;
            hdr_cnt  <= '0;
            pay_left <= '0;
        end else if (beat_done) begin
            case (state)
                P_HEADER: begin
                    if (hdr_cnt == 4'd9) begin
                        pay_left <= (beats.data[15:0] - len_t'(UDP_LEN_EXTRA)) >> 2;
                    end
                    if (beats.last) begin
                        hdr_cnt <= '0;
                    end else if (!hdr_ok) begin
                        state   <= P_DISCARD;
                        hdr_cnt <= '0;
                    end else if (hdr_cnt == 4'(HDR_WORDS - 1)) begin
                        state   <= P_PAYLOAD;
                        hdr_cnt <= '0;
                    end else begin
                        hdr_cnt <= hdr_cnt + 4'd1;
                    end
                end
                P_PAYLOAD: begin
                    pay_left <= pay_left - len_t'(1);
                    if (beats.last) begin
                        state <= P_HEADER;
                    end else if (pay_left == len_t'(1)) begin
                        // trailing words up to last are dropped
                        state <= P_DISCARD;
                    end
                end
                P_DISCARD: begin
                    if (beats.last) begin
                        state <= P_HEADER;
                    end
                end
                default: state <= P_HEADER;
            endcase
        end
    end

endmodule

// File: source/udp_tx_framer.sv
`timescale 1ns/1ps

module udp_tx_framer import net_pkg::*, stream_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        payload_valid,
    input  word_t       payload_data,
    output logic        payload_ready,
    input  len_t        packet_size,
    input  mac_t        local_mac,
    input  ip_t         local_ip,
    input  port_t       local_port,
    input  mac_t        remote_mac,
    input  ip_t         remote_ip,
    input  port_t       remote_port,
    input  logic [15:0] checksum,
    output len_t        ip_total_len,
    stream_if.source    frame
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEADER,
        S_PAYLOAD
    } state_t;

    state_t     state;
    logic [8:0] word_cnt;
    logic [8:0] last_idx;
    len_t       udp_len;
    word_t      hdr_word;
    logic       beat_done;

    ////////////////////////////////////////
    // length fields
    ////////////////////////////////////////

    assign ip_total_len = packet_size + len_t'(IP_LEN_EXTRA);
    assign udp_len      = packet_size + len_t'(UDP_LEN_EXTRA);

    // index of the final payload word in the frame
    assign last_idx = 9'(HDR_WORDS) + 9'(packet_size[10:2]) - 9'd1;

    ////////////////////////////////////////
    // header word select
    ////////////////////////////////////////

    always_comb begin
        case (word_cnt[3:0])
            4'd0:    hdr_word = remote_mac[47:16];
            4'd1:    hdr_word = {remote_mac[15:0], local_mac[47:32]};
            4'd2:    hdr_word = local_mac[31:0];
            4'd3:    hdr_word = {ETHERTYPE_IPV4, IP_VER_IHL_TOS};
            4'd4:    hdr_word = {ip_total_len, 16'h0000};
            4'd5:    hdr_word = {IP_FLAGS_FRAG, IP_TTL_PROTO};
            4'd6:    hdr_word = {checksum, local_ip[31:16]};
            4'd7:    hdr_word = {local_ip[15:0], remote_ip[31:16]};
            4'd8:    hdr_word = {remote_ip[15:0], local_port};
            4'd9:    hdr_word = {remote_port, udp_len};
            // zero udp checksum and pad
            default: hdr_word = '0;
        endcase
    end

    ////////////////////////////////////////
    // output stream
    ////////////////////////////////////////

    assign beat_done = frame.valid && frame.ready;

    always_comb begin
        frame.valid   = 1'b0;
        frame.data    = hdr_word;
        payload_ready = 1'b0;
        case (state)
            // word 0 is offered as soon as payload is waiting
            S_IDLE:    frame.valid = payload_valid;
            S_HEADER:  frame.valid = 1'b1;
            S_PAYLOAD: begin
                frame.valid   = payload_valid;
                frame.data    = payload_data;
                payload_ready = frame.ready;
            end
            default:   frame.valid = 1'b0;
        endcase
    end

    assign frame.last = (state == S_PAYLOAD) && (word_cnt == last_idx) && payload_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            word_cnt <= '0;
        end else if (beat_done) begin
            case (state)
                S_IDLE: begin
                    state    <= S_HEADER;
                    word_cnt <= 9'd1;
                end
                S_HEADER: begin
                    word_cnt <= word_cnt + 9'd1;
                    if (word_cnt == 9'(HDR_WORDS - 1)) begin
                        state <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    if (word_cnt == last_idx) begin
                        state    <= S_IDLE;
                        word_cnt <= '0;
                    end else begin
                        word_cnt <= word_cnt + 9'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule
